//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tb_decode_frontend
FILELIST = vlog.f

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- common/decode_pkg.sv
// shared decode types; opcode values are project-local classes, not the real LoongArch encoding
package decode_pkg;

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  // ====================================================================
  // instruction word views
  // ====================================================================
  typedef struct packed {
    logic [5:0]           opcode;
    logic [10:0]          rsvd;
    logic [REG_IDX_W-1:0] rk;
    logic [REG_IDX_W-1:0] rj;
    logic [REG_IDX_W-1:0] rd;
  } reg_view_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] imm_field;
  } imm_view_t;

  // same word seen as register fields or as one immediate field
  typedef union packed {
    reg_view_t reg_view;
    imm_view_t imm_view;
  } instr_word_u;

  // ====================================================================
  // operand and immediate kinds
  // ====================================================================
  typedef enum logic [1:0] {SRC_R0, SRC_RD, SRC_RJ, SRC_RK} src_kind_e;

  // jd is rd | rj, ra is the link register
  typedef enum logic [1:0] {DEST_R0, DEST_RD, DEST_JD, DEST_RA} dest_kind_e;

  typedef enum logic [3:0] {
    IMM_NONE, IMM_UI5, IMM_UI12, IMM_SI12, IMM_SI14,
    IMM_SI16, IMM_SI20, IMM_SI26, IMM_PC
  } imm_kind_e;

  typedef enum logic [2:0] {
    PRIV_NONE, PRIV_CSR_XCHG, PRIV_CSR_READ, PRIV_CSR_WRITE,
    PRIV_RDCNTVL, PRIV_RDCNTID
  } priv_op_e;

  // opcode classes
  localparam logic [5:0] OPC_ADD     = 6'd0;
  localparam logic [5:0] OPC_ADDI    = 6'd1;
  localparam logic [5:0] OPC_ORI     = 6'd2;
  localparam logic [5:0] OPC_SLLI    = 6'd3;
  localparam logic [5:0] OPC_LU12I   = 6'd4;
  localparam logic [5:0] OPC_PCADDU  = 6'd5;
  localparam logic [5:0] OPC_BL      = 6'd6;
  localparam logic [5:0] OPC_JIRL    = 6'd7;
  localparam logic [5:0] OPC_BEQ     = 6'd8;
  localparam logic [5:0] OPC_CSRXCHG = 6'd9;
  localparam logic [5:0] OPC_RDCNT   = 6'd10;

endpackage

//--- decode/imm_extender.sv
// immediate build from the 26-bit field; pc-relative adds the si20 value to pc_i
`timescale 1ns/10ps
module imm_extender import decode_pkg::*; (
  input  instr_word_u     instr_i,
  input  imm_kind_e       imm_kind_i,
  input  logic [XLEN-1:0] pc_i,
  output logic [XLEN-1:0] imm_o
);

  logic [25:0]     f;
  logic [XLEN-1:0] si20;

  assign f    = instr_i.imm_view.imm_field;
  assign si20 = {{12{f[24]}}, f[24:5]};

  always_comb begin
    case (imm_kind_i)
      IMM_UI5:  imm_o = {27'b0, f[14:10]};
      IMM_UI12: imm_o = {20'b0, f[21:10]};
      IMM_SI12: imm_o = {{20{f[21]}}, f[21:10]};
      IMM_SI14: imm_o = {{18{f[23]}}, f[23:10]};
      IMM_SI16: imm_o = {{16{f[25]}}, f[25:10]};
      IMM_SI20: imm_o = si20;
      // low half of the offset sits in the upper field bits
      IMM_SI26: imm_o = {{6{f[9]}}, f[9:0], f[25:10]};
      IMM_PC:   imm_o = pc_i + si20;
      default:  imm_o = '0;
    endcase
  end

endmodule

//--- decode/operand_decoder.sv
// register index selection and privileged-op refinement for one lane, purely combinational
`timescale 1ns/10ps
module operand_decoder import decode_pkg::*; (
  input  instr_word_u          instr_i,
  input  src_kind_e            src0_kind_i,
  input  src_kind_e            src1_kind_i,
  input  dest_kind_e           dest_kind_i,
  input  priv_op_e             priv_op_i,
  output logic [REG_IDX_W-1:0] src0_o,
  output logic [REG_IDX_W-1:0] src1_o,
  output logic [REG_IDX_W-1:0] dest_o,
  output priv_op_e             priv_op_o
);

  logic [REG_IDX_W-1:0] rd;
  logic [REG_IDX_W-1:0] rj;
  logic [REG_IDX_W-1:0] rk;

  assign rd = instr_i.reg_view.rd;
  assign rj = instr_i.reg_view.rj;
  assign rk = instr_i.reg_view.rk;

  function automatic logic [REG_IDX_W-1:0] pick_src(input src_kind_e kind,
                                                   input logic [REG_IDX_W-1:0] f_rd,
                                                   input logic [REG_IDX_W-1:0] f_rj,
                                                   input logic [REG_IDX_W-1:0] f_rk);
    case (kind)
      SRC_RD:  return f_rd;
      SRC_RJ:  return f_rj;
      SRC_RK:  return f_rk;
      default: return '0;
    endcase
  endfunction

  assign src0_o = pick_src(src0_kind_i, rd, rj, rk);
  assign src1_o = pick_src(src1_kind_i, rd, rj, rk);

  always_comb begin
    case (dest_kind_i)
      DEST_RD: dest_o = rd;
      // jump link target is rd or rj, whichever is set
      DEST_JD: dest_o = rd | rj;
      DEST_RA: dest_o = REG_IDX_W'(1);
      default: dest_o = '0;
    endcase
  end

  // ====================================================================
  // privileged op refinement, rj selects the variant
  // ====================================================================
  always_comb begin
    priv_op_o = priv_op_i;
    if (priv_op_i == PRIV_CSR_XCHG) begin
      if (rj == REG_IDX_W'(0)) begin
        priv_op_o = PRIV_CSR_READ;
      end else if (rj == REG_IDX_W'(1)) begin
        priv_op_o = PRIV_CSR_WRITE;
      end
    end else if (priv_op_i == PRIV_RDCNTVL && rj != '0) begin
      priv_op_o = PRIV_RDCNTID;
    end
  end

endmodule

//--- decode/pre_decoder.sv
// opcode to operand-kind table for one lane; unknown opcodes decode as a nop
`timescale 1ns/10ps
module pre_decoder import decode_pkg::*; (
  input  instr_word_u instr_i,
  output src_kind_e   src0_kind_o,
  output src_kind_e   src1_kind_o,
  output dest_kind_e  dest_kind_o,
  output imm_kind_e   imm_kind_o,
  output priv_op_e    priv_op_o
);

  always_comb begin
    src0_kind_o = SRC_R0;
    src1_kind_o = SRC_R0;
    dest_kind_o = DEST_R0;
    imm_kind_o  = IMM_NONE;
    priv_op_o   = PRIV_NONE;
    case (instr_i.reg_view.opcode)
      OPC_ADD: begin
        src0_kind_o = SRC_RJ;
        src1_kind_o = SRC_RK;
        dest_kind_o = DEST_RD;
      end
      OPC_ADDI: begin
        src0_kind_o = SRC_RJ;
        dest_kind_o = DEST_RD;
        imm_kind_o  = IMM_SI12;
      end
      OPC_ORI: begin
        src0_kind_o = SRC_RJ;
        dest_kind_o = DEST_RD;
        imm_kind_o  = IMM_UI12;
      end
      OPC_SLLI: begin
        src0_kind_o = SRC_RJ;
        dest_kind_o = DEST_RD;
        imm_kind_o  = IMM_UI5;
      end
      OPC_LU12I: begin
        dest_kind_o = DEST_RD;
        imm_kind_o  = IMM_SI20;
      end
      OPC_PCADDU: begin
        dest_kind_o = DEST_RD;
        imm_kind_o  = IMM_PC;
      end
      OPC_BL: begin
        dest_kind_o = DEST_RA;
        imm_kind_o  = IMM_SI26;
      end
      OPC_JIRL: begin
        src0_kind_o = SRC_RJ;
        dest_kind_o = DEST_JD;
        imm_kind_o  = IMM_SI16;
      end
      OPC_BEQ: begin
        src0_kind_o = SRC_RJ;
        src1_kind_o = SRC_RD;
        imm_kind_o  = IMM_SI16;
      end
      OPC_CSRXCHG: begin
        src0_kind_o = SRC_RD;
        src1_kind_o = SRC_RJ;
        dest_kind_o = DEST_RD;
        imm_kind_o  = IMM_SI14;
        priv_op_o   = PRIV_CSR_XCHG;
      end
      OPC_RDCNT: begin
        dest_kind_o = DEST_RD;
        priv_op_o   = PRIV_RDCNTVL;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- ibuf/instr_buffer.sv
// circular multi-lane FIFO; IBUF_DEPTH must be >= FETCH_WIDTH + DECODE_WIDTH, wr_num_i packed from lane 0
`timescale 1ns/10ps
module instr_buffer import decode_pkg::*; #(
  parameter int FETCH_WIDTH  = 2,
  parameter int DECODE_WIDTH = 2,
  parameter int IBUF_DEPTH   = 8
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush_i,
  input  logic                                      wr_valid_i,
  input  logic [$clog2(FETCH_WIDTH+1)-1:0]          wr_num_i,
  input  logic [FETCH_WIDTH-1:0][XLEN-1:0]          wr_instr_i,
  input  logic [FETCH_WIDTH-1:0][XLEN-1:0]          wr_pc_i,
  output logic                                      wr_ready_o,
  output logic [DECODE_WIDTH-1:0]                   rd_valid_o,
  output logic [DECODE_WIDTH-1:0][XLEN-1:0]         rd_instr_o,
  output logic [DECODE_WIDTH-1:0][XLEN-1:0]         rd_pc_o,
  input  logic                                      rd_ready_i
);

  localparam int PTR_W = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(IBUF_DEPTH + 1);

  logic [XLEN-1:0]  instr_q [IBUF_DEPTH];
  logic [XLEN-1:0]  pc_q    [IBUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic [CNT_W-1:0] push_num;
  logic [CNT_W-1:0] pop_num;

  // pointer add with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] wrap_add(input logic [PTR_W-1:0] base,
                                                input int unsigned off);
    int unsigned sum;
    sum = base + off;
    if (sum >= IBUF_DEPTH) begin
      sum = sum - IBUF_DEPTH;
    end
    return sum[PTR_W-1:0];
  endfunction

  assign wr_ready_o = (CNT_W'(IBUF_DEPTH) - count) >= CNT_W'(FETCH_WIDTH);
  assign push       = wr_valid_i & wr_ready_o;
  assign push_num   = push ? CNT_W'(wr_num_i) : '0;

  // pop whatever is presented
  always_comb begin
    pop_num = '0;
    if (rd_ready_i) begin
      pop_num = (count > CNT_W'(DECODE_WIDTH)) ? CNT_W'(DECODE_WIDTH) : count;
    end
  end

  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      rd_valid_o[i] = count > CNT_W'(i);
      rd_instr_o[i] = instr_q[wrap_add(rd_ptr, i)];
      rd_pc_o[i]    = pc_q[wrap_add(rd_ptr, i)];
    end
  end

  // ====================================================================
  // storage
  // ====================================================================
  always_ff @(posedge clk) begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      if (push && (i < wr_num_i)) begin
        instr_q[wrap_add(wr_ptr, i)] <= wr_instr_i[i];
        pc_q[wrap_add(wr_ptr, i)]    <= wr_pc_i[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wrap_add(wr_ptr, push_num);
      rd_ptr <= wrap_add(rd_ptr, pop_num);
      count  <= count + push_num - pop_num;
    end
  end

endmodule

//--- logic/decode_frontend_top.sv
// decode front end top; IBUF_DEPTH must be >= FETCH_WIDTH + DECODE_WIDTH
`timescale 1ns/10ps
module decode_frontend_top import decode_pkg::*; #(
  parameter int FETCH_WIDTH  = 2,
  parameter int DECODE_WIDTH = 2,
  parameter int IBUF_DEPTH   = 8
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   flush_i,
  input  logic                                   fetch_valid_i,
  input  logic [$clog2(FETCH_WIDTH+1)-1:0]       fetch_num_i,
  input  logic [FETCH_WIDTH-1:0][XLEN-1:0]       fetch_instr_i,
  input  logic [FETCH_WIDTH-1:0][XLEN-1:0]       fetch_pc_i,
  output logic                                   fetch_ready_o,
  output logic [DECODE_WIDTH-1:0]                out_valid_o,
  output logic [DECODE_WIDTH-1:0][XLEN-1:0]      out_pc_o,
  output logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] out_src0_o,
  output logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] out_src1_o,
  output logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] out_dest_o,
  output logic [DECODE_WIDTH-1:0][XLEN-1:0]      out_imm_o,
  output priv_op_e [DECODE_WIDTH-1:0]            out_priv_op_o,
  input  logic                                   out_ready_i
);

  logic [DECODE_WIDTH-1:0]                rd_valid;
  logic [DECODE_WIDTH-1:0][XLEN-1:0]      rd_instr;
  logic [DECODE_WIDTH-1:0][XLEN-1:0]      rd_pc;
  logic                                   rd_ready;
  src_kind_e  [DECODE_WIDTH-1:0]          src0_kind;
  src_kind_e  [DECODE_WIDTH-1:0]          src1_kind;
  dest_kind_e [DECODE_WIDTH-1:0]          dest_kind;
  imm_kind_e  [DECODE_WIDTH-1:0]          imm_kind;
  priv_op_e   [DECODE_WIDTH-1:0]          pre_priv_op;
  priv_op_e   [DECODE_WIDTH-1:0]          dec_priv_op;
  logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] dec_src0;
  logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] dec_src1;
  logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] dec_dest;
  logic [DECODE_WIDTH-1:0][XLEN-1:0]      dec_imm;

  // ====================================================================
  // instruction buffer
  // ====================================================================
  instr_buffer #(
    .FETCH_WIDTH  (FETCH_WIDTH),
    .DECODE_WIDTH (DECODE_WIDTH),
    .IBUF_DEPTH   (IBUF_DEPTH)
  ) u_instr_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .wr_valid_i (fetch_valid_i),
    .wr_num_i   (fetch_num_i),
    .wr_instr_i (fetch_instr_i),
    .wr_pc_i    (fetch_pc_i),
    .wr_ready_o (fetch_ready_o),
    .rd_valid_o (rd_valid),
    .rd_instr_o (rd_instr),
    .rd_pc_o    (rd_pc),
    .rd_ready_i (rd_ready)
  );

  // ====================================================================
  // per-lane decode
  // ====================================================================
  for (genvar i = 0; i < DECODE_WIDTH; i++) begin : g_lane
    pre_decoder u_pre_decoder (
      .instr_i     (rd_instr[i]),
      .src0_kind_o (src0_kind[i]),
      .src1_kind_o (src1_kind[i]),
      .dest_kind_o (dest_kind[i]),
      .imm_kind_o  (imm_kind[i]),
      .priv_op_o   (pre_priv_op[i])
    );

    operand_decoder u_operand_decoder (
      .instr_i     (rd_instr[i]),
      .src0_kind_i (src0_kind[i]),
      .src1_kind_i (src1_kind[i]),
      .dest_kind_i (dest_kind[i]),
      .priv_op_i   (pre_priv_op[i]),
      .src0_o      (dec_src0[i]),
      .src1_o      (dec_src1[i]),
      .dest_o      (dec_dest[i]),
      .priv_op_o   (dec_priv_op[i])
    );

    imm_extender u_imm_extender (
      .instr_i    (rd_instr[i]),
      .imm_kind_i (imm_kind[i]),
      .pc_i       (rd_pc[i]),
      .imm_o      (dec_imm[i])
    );
  end

  issue_stage #(
    .DECODE_WIDTH (DECODE_WIDTH)
  ) u_issue_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .in_valid_i    (rd_valid),
    .in_pc_i       (rd_pc),
    .in_src0_i     (dec_src0),
    .in_src1_i     (dec_src1),
    .in_dest_i     (dec_dest),
    .in_imm_i      (dec_imm),
    .in_priv_op_i  (dec_priv_op),
    .in_ready_o    (rd_ready),
    .out_valid_o   (out_valid_o),
    .out_pc_o      (out_pc_o),
    .out_src0_o    (out_src0_o),
    .out_src1_o    (out_src1_o),
    .out_dest_o    (out_dest_o),
    .out_imm_o     (out_imm_o),
    .out_priv_op_o (out_priv_op_o),
    .out_ready_i   (out_ready_i)
  );

endmodule

//--- logic/issue_stage.sv
// one registered slot per lane; reloads when empty or out_ready_i is high, flush drops all lanes
`timescale 1ns/10ps
module issue_stage import decode_pkg::*; #(
  parameter int DECODE_WIDTH = 2
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   flush_i,
  input  logic [DECODE_WIDTH-1:0]                in_valid_i,
  input  logic [DECODE_WIDTH-1:0][XLEN-1:0]      in_pc_i,
  input  logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] in_src0_i,
  input  logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] in_src1_i,
  input  logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] in_dest_i,
  input  logic [DECODE_WIDTH-1:0][XLEN-1:0]      in_imm_i,
  input  priv_op_e [DECODE_WIDTH-1:0]            in_priv_op_i,
  output logic                                   in_ready_o,
  output logic [DECODE_WIDTH-1:0]                out_valid_o,
  output logic [DECODE_WIDTH-1:0][XLEN-1:0]      out_pc_o,
  output logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] out_src0_o,
  output logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] out_src1_o,
  output logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] out_dest_o,
  output logic [DECODE_WIDTH-1:0][XLEN-1:0]      out_imm_o,
  output priv_op_e [DECODE_WIDTH-1:0]            out_priv_op_o,
  input  logic                                   out_ready_i
);

  // whole group moves at once
  assign in_ready_o = ~(|out_valid_o) | out_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= '0;
    end else if (flush_i) begin
      out_valid_o <= '0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready_o) begin
      out_pc_o      <= in_pc_i;
      out_src0_o    <= in_src0_i;
      out_src1_o    <= in_src1_i;
      out_dest_o    <= in_dest_i;
      out_imm_o     <= in_imm_i;
      out_priv_op_o <= in_priv_op_i;
    end
  end

endmodule

//--- verif/decode_frontend_checker.sv
// output protocol assertions, bound into every decode_frontend_top instance
`timescale 1ns/10ps
module decode_frontend_checker import decode_pkg::*; #(
  parameter int DECODE_WIDTH = 2
) (
  input logic                                   clk,
  input logic                                   rst_n,
  input logic                                   flush_i,
  input logic                                   out_ready_i,
  input logic [DECODE_WIDTH-1:0]                out_valid_o,
  input logic [DECODE_WIDTH-1:0][XLEN-1:0]      out_pc_o,
  input logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] out_src0_o,
  input logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] out_src1_o,
  input logic [DECODE_WIDTH-1:0][REG_IDX_W-1:0] out_dest_o,
  input logic [DECODE_WIDTH-1:0][XLEN-1:0]      out_imm_o,
  input priv_op_e [DECODE_WIDTH-1:0]            out_priv_op_o
);

  idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> out_valid_o == '0)
    else $error("out_valid_o set right after reset");

  // lane 0 first, no gaps
  valid_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid_o & (out_valid_o + 1'b1)) == '0)
    else $error("out_valid_o lanes not contiguous from lane 0");

  stable_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (|out_valid_o && !out_ready_i && !flush_i) |=>
      ($stable(out_valid_o) && $stable(out_pc_o) && $stable(out_src0_o) &&
       $stable(out_src1_o) && $stable(out_dest_o) && $stable(out_imm_o) &&
       $stable(out_priv_op_o)))
    else $error("outputs changed while stalled");

  clear_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flush_i |=> out_valid_o == '0)
    else $error("out_valid_o not cleared after flush");

endmodule

bind decode_frontend_top decode_frontend_checker #(
  .DECODE_WIDTH (DECODE_WIDTH)
) u_checker (
  .clk           (clk),
  .rst_n         (rst_n),
  .flush_i       (flush_i),
  .out_ready_i   (out_ready_i),
  .out_valid_o   (out_valid_o),
  .out_pc_o      (out_pc_o),
  .out_src0_o    (out_src0_o),
  .out_src1_o    (out_src1_o),
  .out_dest_o    (out_dest_o),
  .out_imm_o     (out_imm_o),
  .out_priv_op_o (out_priv_op_o)
);

//--- verif/tb_decode_frontend.sv
// self-checking testbench for decode_frontend_top; fixed seed, stops at the first mismatch
`timescale 1ns/10ps
module tb_decode_frontend import decode_pkg::*; ();

  localparam int FW = 2;
  localparam int DW = 2;
  localparam int DEPTH = 8;
  // the tests need about 1500 cycles
  localparam int TIMEOUT_CYCLES = 6000;

  logic                      clk;
  logic                      rst_n;
  logic                      flush_i;
  logic                      fetch_valid_i;
  logic [1:0]                fetch_num_i;
  logic [FW-1:0][XLEN-1:0]   fetch_instr_i;
  logic [FW-1:0][XLEN-1:0]   fetch_pc_i;
  logic                      fetch_ready_o;
  logic [DW-1:0]             out_valid_o;
  logic [DW-1:0][XLEN-1:0]   out_pc_o;
  logic [DW-1:0][REG_IDX_W-1:0] out_src0_o;
  logic [DW-1:0][REG_IDX_W-1:0] out_src1_o;
  logic [DW-1:0][REG_IDX_W-1:0] out_dest_o;
  logic [DW-1:0][XLEN-1:0]   out_imm_o;
  priv_op_e [DW-1:0]         out_priv_op_o;
  logic                      out_ready_i = 1'b0;

  // expected word is {pc, src0, src1, dest, imm, priv}
  logic [81:0] exp_q[$];
  string       test_name = "reset";
  bit          bp_mode = 1'b0;
  bit          hold_back;
  bit          full_seen = 1'b0;
  int unsigned cycle_cnt = 0;

  decode_frontend_top #(
    .FETCH_WIDTH  (FW),
    .DECODE_WIDTH (DW),
    .IBUF_DEPTH   (DEPTH)
  ) u_decode_frontend_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_num_i   (fetch_num_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_ready_o (fetch_ready_o),
    .out_valid_o   (out_valid_o),
    .out_pc_o      (out_pc_o),
    .out_src0_o    (out_src0_o),
    .out_src1_o    (out_src1_o),
    .out_dest_o    (out_dest_o),
    .out_imm_o     (out_imm_o),
    .out_priv_op_o (out_priv_op_o),
    .out_ready_i   (out_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  // ====================================================================
  // reference model
  // ====================================================================
  function automatic logic [81:0] decode_ref(input logic [31:0] ins, input logic [31:0] pc);
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [25:0] f;
    logic [4:0]  s0;
    logic [4:0]  s1;
    logic [4:0]  dst;
    logic [31:0] imm;
    logic [2:0]  priv;
    rd   = ins[4:0];
    rj   = ins[9:5];
    rk   = ins[14:10];
    f    = ins[25:0];
    s0   = '0;
    s1   = '0;
    dst  = '0;
    imm  = '0;
    priv = PRIV_NONE;
    case (ins[31:26])
      OPC_ADD: begin
        s0  = rj;
        s1  = rk;
        dst = rd;
      end
      OPC_ADDI: begin
        s0  = rj;
        dst = rd;
        imm = 32'($signed(f[21:10]));
      end
      OPC_ORI: begin
        s0  = rj;
        dst = rd;
        imm = 32'(f[21:10]);
      end
      OPC_SLLI: begin
        s0  = rj;
        dst = rd;
        imm = 32'(f[14:10]);
      end
      OPC_LU12I: begin
        dst = rd;
        imm = 32'($signed(f[24:5]));
      end
      OPC_PCADDU: begin
        dst = rd;
        imm = pc + 32'($signed(f[24:5]));
      end
      OPC_BL: begin
        dst = 5'd1;
        imm = 32'($signed({f[9:0], f[25:10]}));
      end
      OPC_JIRL: begin
        s0  = rj;
        dst = rd | rj;
        imm = 32'($signed(f[25:10]));
      end
      OPC_BEQ: begin
        s0  = rj;
        s1  = rd;
        imm = 32'($signed(f[25:10]));
      end
      OPC_CSRXCHG: begin
        s0   = rd;
        s1   = rj;
        dst  = rd;
        imm  = 32'($signed(f[23:10]));
        priv = (rj == 5'd0) ? PRIV_CSR_READ : (rj == 5'd1) ? PRIV_CSR_WRITE : PRIV_CSR_XCHG;
      end
      OPC_RDCNT: begin
        dst  = rd;
        priv = (rj != 5'd0) ? PRIV_RDCNTID : PRIV_RDCNTVL;
      end
      default: begin
      end
    endcase
    return {pc, s0, s1, dst, imm, priv};
  endfunction

  task automatic compare_lane(input int lane);
    logic [81:0] exp_v;
    logic [81:0] act_v;
    assert (exp_q.size() != 0)
      else abort_run($sformatf("delivery on lane %0d with no instruction pending", lane));
    exp_v = exp_q.pop_front();
    act_v = {out_pc_o[lane], out_src0_o[lane], out_src1_o[lane], out_dest_o[lane],
             out_imm_o[lane], 3'(out_priv_op_o[lane])};
    assert (act_v === exp_v)
      else abort_run($sformatf("ERR %s expected %h actual %h", test_name, exp_v, act_v));
  endtask

  // ====================================================================
  // scoreboard, sampled mid-cycle where inputs and outputs are settled
  // ====================================================================
  always @(negedge clk) begin
    if (rst_n) begin
      if (!fetch_ready_o) begin
        full_seen = 1'b1;
      end
      if (flush_i) begin
        exp_q.delete();
      end else begin
        for (int l = 0; l < DW; l++) begin
          if (out_ready_i && out_valid_o[l]) begin
            compare_lane(l);
          end
        end
        for (int i = 0; i < FW; i++) begin
          if (fetch_valid_i && fetch_ready_o && i < int'(fetch_num_i)) begin
            exp_q.push_back(decode_ref(fetch_instr_i[i], fetch_pc_i[i]));
          end
        end
      end
    end
  end

  // sink ready, 40 percent when back-pressure is on
  always @(posedge clk) begin
    hold_back = bp_mode && ($urandom_range(99) >= 40);
    #1;
    out_ready_i = !hold_back;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    assert (cycle_cnt < TIMEOUT_CYCLES)
      else abort_run($sformatf("timeout after %0d cycles, the DUT stopped making progress",
                               cycle_cnt));
  end

  // ====================================================================
  // stimulus
  // ====================================================================
  function automatic logic [31:0] make_instr(input logic [5:0] opc);
    return {opc, 26'($urandom)};
  endfunction

  function automatic logic [31:0] set_rj(input logic [31:0] ins, input logic [4:0] rj);
    return {ins[31:10], rj, ins[4:0]};
  endfunction

  task automatic fill_lanes();
    for (int i = 0; i < FW; i++) begin
      // 11 and 12 are unlisted opcodes
      fetch_instr_i[i] = make_instr(6'($urandom_range(12)));
      fetch_pc_i[i]    = $urandom & 32'hffff_fffc;
    end
  endtask

  // hold the group until the buffer takes it
  task automatic push_group(input int n);
    bit taken;
    taken         = 1'b0;
    fetch_valid_i = 1'b1;
    fetch_num_i   = 2'(n);
    while (!taken) begin
      @(negedge clk);
      taken = fetch_ready_o;
      @(posedge clk);
      #1;
    end
    fetch_valid_i = 1'b0;
  endtask

  task automatic send_one(input logic [31:0] ins);
    fill_lanes();
    fetch_instr_i[0] = ins;
    push_group(1);
  endtask

  task automatic send_stream(input int total);
    int sent;
    int n;
    sent = 0;
    while (sent < total) begin
      n = $urandom_range(FW, 1);
      if (n > total - sent) begin
        n = total - sent;
      end
      fill_lanes();
      push_group(n);
      sent += n;
    end
  endtask

  task automatic wait_drain();
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0);
  endtask

  initial begin
    void'($urandom(84044));
    rst_n         = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_num_i   = '0;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (out_valid_o == '0 && fetch_ready_o)
      else abort_run("outputs not idle or buffer not ready after reset");
    @(posedge clk);
    #1;

    test_name = "table";
    for (int op = 0; op <= 11; op++) begin
      send_one(make_instr((op == 11) ? 6'd63 : 6'(op)));
      wait_drain();
    end

    test_name = "special";
    send_one(set_rj(make_instr(OPC_CSRXCHG), 5'd0));
    send_one(set_rj(make_instr(OPC_CSRXCHG), 5'd1));
    send_one(set_rj(make_instr(OPC_CSRXCHG), 5'($urandom_range(31, 2))));
    send_one(set_rj(make_instr(OPC_RDCNT), 5'd0));
    send_one(set_rj(make_instr(OPC_RDCNT), 5'($urandom_range(31, 1))));
    send_one(set_rj(make_instr(OPC_JIRL), 5'($urandom_range(31, 1))));
    wait_drain();

    test_name = "stream";
    send_stream(300);
    wait_drain();

    test_name = "backpressure";
    bp_mode   = 1'b1;
    send_stream(300);
    wait_drain();
    assert (full_seen) else abort_run("fetch_ready_o never dropped under back-pressure");

    // flush edge also carries a push that must be dropped
    test_name = "flush";
    send_stream(40);
    fill_lanes();
    fetch_valid_i = 1'b1;
    fetch_num_i   = 2'(FW);
    flush_i       = 1'b1;
    @(posedge clk);
    #1;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    @(negedge clk);
    assert (out_valid_o == '0 && fetch_ready_o)
      else abort_run("outputs or buffer not cleared after flush");
    @(posedge clk);
    #1;
    send_stream(60);
    bp_mode = 1'b0;
    wait_drain();

    if (exp_q.size() == 0 && out_valid_o == '0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      abort_run($sformatf("%0d instructions undelivered or extra lanes valid at the end",
                          exp_q.size()));
    end
  end

endmodule

//--- vlog.f
common/decode_pkg.sv
ibuf/instr_buffer.sv
decode/pre_decoder.sv
decode/operand_decoder.sv
decode/imm_extender.sv
logic/issue_stage.sv
logic/decode_frontend_top.sv
verif/decode_frontend_checker.sv
verif/tb_decode_frontend.sv
